//--- source/rocc_bridge_pkg.sv
package rocc_bridge_pkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////

  // manycore word address and data
  localparam int mc_addr_width = 14;
  localparam int mc_data_width = 32;

  // mesh coordinates
  localparam int mc_x_width = 4;
  localparam int mc_y_width = 5;

  // rocket side
  localparam int rocc_addr_width = 32;
  localparam int rocc_reg_width = 5;
  localparam int rocc_funct7_width = 7;

  // byte address seen by the manycore, word address plus two low bits
  localparam int mc_byte_addr_width = mc_addr_width + 2;

  // segment covers the rocket address bits above the manycore byte address
  localparam int seg_addr_width = rocc_addr_width - mc_byte_addr_width;

  ////////////////////////////////////////////////////////////
  // encodings
  ////////////////////////////////////////////////////////////

  // custom instruction funct7 codes
  typedef enum logic [rocc_funct7_width-1:0] {
    funct7_write    = 7'd0,
    funct7_read     = 7'd1,
    funct7_seg_addr = 7'd2,
    funct7_mc_reset = 7'd3
  } rocc_funct7_e;

  // rocket memory command, word accesses only
  typedef enum logic {
    mem_load  = 1'b0,
    mem_store = 1'b1
  } rocc_mem_cmd_e;

  // manycore packet operation
  typedef enum logic {
    op_remote_load  = 1'b0,
    op_remote_store = 1'b1
  } mc_op_e;

  ////////////////////////////////////////////////////////////
  // structs
  ////////////////////////////////////////////////////////////

  // low bits of rs1 for write and read commands
  typedef struct packed {
    logic [mc_y_width-1:0]    y_cord;
    logic [mc_x_width-1:0]    x_cord;
    logic [mc_addr_width-1:0] word_addr;
  } rocc_mc_addr_t;

  // outgoing packet toward the mesh node, mask is always full-word
  typedef struct packed {
    mc_op_e                   op;
    logic [mc_addr_width-1:0] addr;
    logic [mc_data_width-1:0] data;
    logic [mc_x_width-1:0]    x_cord;
    logic [mc_y_width-1:0]    y_cord;
  } mc_packet_t;

endpackage

//--- source/mc_read_if.sv
`timescale 1ns/1ps

// read tracking between the command decoder and the response merger
interface mc_read_if;

  // accepted read strobe and its destination register
  logic                                      issue;
  logic [rocc_bridge_pkg::rocc_reg_width-1:0] issue_rd;

  // read in flight and the register it writes back to
  logic                                      pending;
  logic [rocc_bridge_pkg::rocc_reg_width-1:0] pending_rd;

  modport decoder (
    output issue,
    output issue_rd,
    input  pending
  );

  // the merger keeps pending_rd for the response
  modport merge (
    input  issue,
    input  issue_rd,
    output pending,
    output pending_rd
  );

endinterface

//--- source/rocc_cmd_decoder.sv
`timescale 1ns/1ps

module rocc_cmd_decoder (
  input  logic                                          rocket_clk_i,
  input  logic                                          rocket_reset_i,

  // core command
  input  logic                                          cmd_valid_i,
  input  rocc_bridge_pkg::rocc_funct7_e                 cmd_funct7_i,
  input  logic [rocc_bridge_pkg::rocc_reg_width-1:0]    cmd_rd_i,
  input  logic [rocc_bridge_pkg::rocc_addr_width-1:0]   cmd_rs1_i,
  input  logic [rocc_bridge_pkg::mc_data_width-1:0]     cmd_rs2_i,
  input  logic                                          cmd_ready_i,

  // segment register toward the memory port
  output logic [rocc_bridge_pkg::seg_addr_width-1:0]    seg_addr_o,

  // outgoing packet
  output logic                                          mc_out_v_o,
  output rocc_bridge_pkg::mc_op_e                       mc_out_op_o,
  output logic [rocc_bridge_pkg::mc_addr_width-1:0]     mc_out_addr_o,
  output logic [rocc_bridge_pkg::mc_data_width-1:0]     mc_out_data_o,
  output logic [rocc_bridge_pkg::mc_x_width-1:0]        mc_out_x_o,
  output logic [rocc_bridge_pkg::mc_y_width-1:0]        mc_out_y_o,
  input  logic                                          mc_out_ready_i,

  output logic                                          reset_manycore_o,

  mc_read_if.decoder                                    read
);

  logic                                        is_write;
  logic                                        is_read;
  logic                                        is_seg_addr;
  logic                                        is_mc_reset;
  logic                                        cmd_accept;
  logic                                        reset_manycore_r;
  logic [rocc_bridge_pkg::seg_addr_width-1:0]  seg_addr_r;
  rocc_bridge_pkg::rocc_mc_addr_t              rs1_addr;
  rocc_bridge_pkg::mc_packet_t                 packet;

  ////////////////////////////////////////////////////////////
  // command decode
  ////////////////////////////////////////////////////////////

  assign is_write    = (cmd_funct7_i == rocc_bridge_pkg::funct7_write);
  assign is_read     = (cmd_funct7_i == rocc_bridge_pkg::funct7_read);
  assign is_seg_addr = (cmd_funct7_i == rocc_bridge_pkg::funct7_seg_addr);
  assign is_mc_reset = (cmd_funct7_i == rocc_bridge_pkg::funct7_mc_reset);

  // core handshake
  assign cmd_accept = cmd_valid_i & cmd_ready_i;

  ////////////////////////////////////////////////////////////
  // manycore reset pulse and segment register
  ////////////////////////////////////////////////////////////

  // high for the single cycle after the command
  always_ff @(posedge rocket_clk_i) begin
    if (rocket_reset_i) begin
      reset_manycore_r <= 1'b0;
    end else begin
      reset_manycore_r <= cmd_accept & is_mc_reset;
    end
  end

  // byte address segment, taken from rs1 above the manycore byte address
  always_ff @(posedge rocket_clk_i) begin
    if (cmd_accept && is_seg_addr) begin
      seg_addr_r <= cmd_rs1_i[rocc_bridge_pkg::rocc_addr_width-1:
                              rocc_bridge_pkg::mc_byte_addr_width];
    end
  end

  assign reset_manycore_o = reset_manycore_r;
  assign seg_addr_o       = seg_addr_r;

  ////////////////////////////////////////////////////////////
  // packet toward the manycore
  ////////////////////////////////////////////////////////////

  assign rs1_addr = cmd_rs1_i[$bits(rocc_bridge_pkg::rocc_mc_addr_t)-1:0];

  assign packet.op     = is_write ? rocc_bridge_pkg::op_remote_store
                                  : rocc_bridge_pkg::op_remote_load;
  assign packet.addr   = rs1_addr.word_addr;
  assign packet.data   = cmd_rs2_i;
  assign packet.x_cord = rs1_addr.x_cord;
  assign packet.y_cord = rs1_addr.y_cord;

  // no new access while a read is still waiting for its data
  assign mc_out_v_o    = cmd_valid_i & (is_write | is_read) & ~read.pending;
  assign mc_out_op_o   = packet.op;
  assign mc_out_addr_o = packet.addr;
  assign mc_out_data_o = packet.data;
  assign mc_out_x_o    = packet.x_cord;
  assign mc_out_y_o    = packet.y_cord;

  // accepted read, the packet leaves in the same cycle
  assign read.issue    = cmd_accept & is_read & mc_out_ready_i;
  assign read.issue_rd = cmd_rd_i;

endmodule

//--- source/mc_mem_port.sv
`timescale 1ns/1ps

module mc_mem_port (
  input  logic                                          rocket_clk_i,
  input  logic                                          rocket_reset_i,

  input  logic [rocc_bridge_pkg::seg_addr_width-1:0]    seg_addr_i,

  // incoming manycore request
  input  logic                                          mc_in_v_i,
  input  logic [rocc_bridge_pkg::mc_addr_width-1:0]     mc_in_addr_i,
  input  logic [rocc_bridge_pkg::mc_data_width-1:0]     mc_in_data_i,
  input  logic                                          mc_in_we_i,
  output logic                                          mc_in_yumi_o,

  // rocket memory request
  output logic                                          mem_req_valid_o,
  output logic [rocc_bridge_pkg::rocc_addr_width-1:0]   mem_req_addr_o,
  output rocc_bridge_pkg::rocc_mem_cmd_e                mem_req_cmd_o,
  output logic [rocc_bridge_pkg::mc_data_width-1:0]     mem_req_data_o,
  input  logic                                          mem_req_ready_i,

  // rocket memory response
  input  logic                                          mem_resp_valid_i,
  input  rocc_bridge_pkg::rocc_mem_cmd_e                mem_resp_cmd_i,
  input  logic [rocc_bridge_pkg::mc_data_width-1:0]     mem_resp_data_i,

  // load data back to the manycore
  output logic                                          mc_returning_v_o,
  output logic [rocc_bridge_pkg::mc_data_width-1:0]     mc_returning_data_o,

  output logic                                          outstanding_o
);

  logic outstanding_r;
  logic launch;

  // segment, word address, then the byte offset
  function automatic logic [rocc_bridge_pkg::rocc_addr_width-1:0] get_rocket_addr(
    input logic [rocc_bridge_pkg::seg_addr_width-1:0] seg,
    input logic [rocc_bridge_pkg::mc_addr_width-1:0]  word_addr
  );
    return {seg, word_addr, 2'b00};
  endfunction

  ////////////////////////////////////////////////////////////
  // request toward rocket
  ////////////////////////////////////////////////////////////

  // responses may come back out of order, so only one at a time
  assign mem_req_valid_o = mc_in_v_i & ~outstanding_r;
  assign mem_req_addr_o  = get_rocket_addr(seg_addr_i, mc_in_addr_i);
  assign mem_req_cmd_o   = mc_in_we_i ? rocc_bridge_pkg::mem_store
                                      : rocc_bridge_pkg::mem_load;
  assign mem_req_data_o  = mc_in_data_i;

  assign launch = mem_req_valid_o & mem_req_ready_i;

  // the request leaves the incoming queue only once rocket takes it
  assign mc_in_yumi_o = launch;

  ////////////////////////////////////////////////////////////
  // outstanding request flag
  ////////////////////////////////////////////////////////////

  always_ff @(posedge rocket_clk_i) begin
    if (rocket_reset_i) begin
      outstanding_r <= 1'b0;
    end else if (mem_resp_valid_i) begin
      outstanding_r <= 1'b0;
    end else if (launch) begin
      outstanding_r <= 1'b1;
    end
  end

  assign outstanding_o = outstanding_r;

  ////////////////////////////////////////////////////////////
  // response back to the manycore
  ////////////////////////////////////////////////////////////

  // stores finish silently, only loads carry data back
  assign mc_returning_v_o    = mem_resp_valid_i & (mem_resp_cmd_i == rocc_bridge_pkg::mem_load);
  assign mc_returning_data_o = mem_resp_data_i;

endmodule

//--- source/rocc_resp_merge.sv
`timescale 1ns/1ps

module rocc_resp_merge (
  input  logic                                        rocket_clk_i,
  input  logic                                        rocket_reset_i,

  input  logic                                        mc_out_ready_i,

  // data returned for a manycore read
  input  logic                                        mc_returned_v_i,
  input  logic [rocc_bridge_pkg::mc_data_width-1:0]   mc_returned_data_i,

  input  logic                                        mem_outstanding_i,

  // core side
  output logic                                        core_cmd_ready_o,
  output logic                                        core_resp_valid_o,
  output logic [rocc_bridge_pkg::rocc_reg_width-1:0]  core_resp_rd_o,
  output logic [rocc_bridge_pkg::mc_data_width-1:0]   core_resp_data_o,
  output logic                                        acc_busy_o,

  mc_read_if.merge                                    read
);

  ////////////////////////////////////////////////////////////
  // in-flight read
  ////////////////////////////////////////////////////////////

  // cleared by the returned data, set by an accepted read
  always_ff @(posedge rocket_clk_i) begin
    if (rocket_reset_i) begin
      read.pending <= 1'b0;
    end else if (mc_returned_v_i) begin
      read.pending <= 1'b0;
    end else if (read.issue) begin
      read.pending <= 1'b1;
    end
  end

  // destination register of the read
  always_ff @(posedge rocket_clk_i) begin
    if (read.issue) begin
      read.pending_rd <= read.issue_rd;
    end
  end

  ////////////////////////////////////////////////////////////
  // core outputs
  ////////////////////////////////////////////////////////////

  // the core cannot stall the response
  assign core_resp_valid_o = mc_returned_v_i;
  assign core_resp_rd_o    = read.pending_rd;
  assign core_resp_data_o  = mc_returned_data_i;

  assign core_cmd_ready_o  = mc_out_ready_i & ~read.pending;
  assign acc_busy_o        = read.pending | mem_outstanding_i;

endmodule

//--- source/rocc_bridge_top.sv
`timescale 1ns/1ps

module rocc_bridge_top (
  input  logic                                          rocket_clk_i,
  input  logic                                          rocket_reset_i,

  // core command
  input  logic                                          core_cmd_valid_i,
  input  rocc_bridge_pkg::rocc_funct7_e                 core_cmd_funct7_i,
  input  logic [rocc_bridge_pkg::rocc_reg_width-1:0]    core_cmd_rd_i,
  input  logic [rocc_bridge_pkg::rocc_addr_width-1:0]   core_cmd_rs1_i,
  input  logic [rocc_bridge_pkg::mc_data_width-1:0]     core_cmd_rs2_i,
  output logic                                          core_cmd_ready_o,

  // core response
  output logic                                          core_resp_valid_o,
  output logic [rocc_bridge_pkg::rocc_reg_width-1:0]    core_resp_rd_o,
  output logic [rocc_bridge_pkg::mc_data_width-1:0]     core_resp_data_o,

  output logic                                          acc_busy_o,

  // outgoing packet to the mesh node
  output logic                                          mc_out_v_o,
  output rocc_bridge_pkg::mc_op_e                       mc_out_op_o,
  output logic [rocc_bridge_pkg::mc_addr_width-1:0]     mc_out_addr_o,
  output logic [rocc_bridge_pkg::mc_data_width-1:0]     mc_out_data_o,
  output logic [rocc_bridge_pkg::mc_x_width-1:0]        mc_out_x_o,
  output logic [rocc_bridge_pkg::mc_y_width-1:0]        mc_out_y_o,
  input  logic                                          mc_out_ready_i,

  // data returned for a read
  input  logic                                          mc_returned_v_i,
  input  logic [rocc_bridge_pkg::mc_data_width-1:0]     mc_returned_data_i,

  // incoming manycore request
  input  logic                                          mc_in_v_i,
  input  logic [rocc_bridge_pkg::mc_addr_width-1:0]     mc_in_addr_i,
  input  logic [rocc_bridge_pkg::mc_data_width-1:0]     mc_in_data_i,
  input  logic                                          mc_in_we_i,
  output logic                                          mc_in_yumi_o,

  // rocket memory
  output logic                                          mem_req_valid_o,
  output logic [rocc_bridge_pkg::rocc_addr_width-1:0]   mem_req_addr_o,
  output rocc_bridge_pkg::rocc_mem_cmd_e                mem_req_cmd_o,
  output logic [rocc_bridge_pkg::mc_data_width-1:0]     mem_req_data_o,
  input  logic                                          mem_req_ready_i,
  input  logic                                          mem_resp_valid_i,
  input  rocc_bridge_pkg::rocc_mem_cmd_e                mem_resp_cmd_i,
  input  logic [rocc_bridge_pkg::mc_data_width-1:0]     mem_resp_data_i,

  // load data back to the manycore
  output logic                                          mc_returning_v_o,
  output logic [rocc_bridge_pkg::mc_data_width-1:0]     mc_returning_data_o,

  output logic                                          reset_manycore_o
);

  logic [rocc_bridge_pkg::seg_addr_width-1:0] seg_addr;
  logic                                       mem_outstanding;

  mc_read_if i_read_if ();

  ////////////////////////////////////////////////////////////
  // command path toward the manycore
  ////////////////////////////////////////////////////////////

  rocc_cmd_decoder i_rocc_cmd_decoder (
    .rocket_clk_i     (rocket_clk_i),
    .rocket_reset_i   (rocket_reset_i),
    .cmd_valid_i      (core_cmd_valid_i),
    .cmd_funct7_i     (core_cmd_funct7_i),
    .cmd_rd_i         (core_cmd_rd_i),
    .cmd_rs1_i        (core_cmd_rs1_i),
    .cmd_rs2_i        (core_cmd_rs2_i),
    .cmd_ready_i      (core_cmd_ready_o),
    .seg_addr_o       (seg_addr),
    .mc_out_v_o       (mc_out_v_o),
    .mc_out_op_o      (mc_out_op_o),
    .mc_out_addr_o    (mc_out_addr_o),
    .mc_out_data_o    (mc_out_data_o),
    .mc_out_x_o       (mc_out_x_o),
    .mc_out_y_o       (mc_out_y_o),
    .mc_out_ready_i   (mc_out_ready_i),
    .reset_manycore_o (reset_manycore_o),
    .read             (i_read_if.decoder)
  );

  ////////////////////////////////////////////////////////////
  // memory path toward rocket
  ////////////////////////////////////////////////////////////

  mc_mem_port i_mc_mem_port (
    .rocket_clk_i        (rocket_clk_i),
    .rocket_reset_i      (rocket_reset_i),
    .seg_addr_i          (seg_addr),
    .mc_in_v_i           (mc_in_v_i),
    .mc_in_addr_i        (mc_in_addr_i),
    .mc_in_data_i        (mc_in_data_i),
    .mc_in_we_i          (mc_in_we_i),
    .mc_in_yumi_o        (mc_in_yumi_o),
    .mem_req_valid_o     (mem_req_valid_o),
    .mem_req_addr_o      (mem_req_addr_o),
    .mem_req_cmd_o       (mem_req_cmd_o),
    .mem_req_data_o      (mem_req_data_o),
    .mem_req_ready_i     (mem_req_ready_i),
    .mem_resp_valid_i    (mem_resp_valid_i),
    .mem_resp_cmd_i      (mem_resp_cmd_i),
    .mem_resp_data_i     (mem_resp_data_i),
    .mc_returning_v_o    (mc_returning_v_o),
    .mc_returning_data_o (mc_returning_data_o),
    .outstanding_o       (mem_outstanding)
  );

  ////////////////////////////////////////////////////////////
  // response merge
  ////////////////////////////////////////////////////////////

  rocc_resp_merge i_rocc_resp_merge (
    .rocket_clk_i       (rocket_clk_i),
    .rocket_reset_i     (rocket_reset_i),
    .mc_out_ready_i     (mc_out_ready_i),
    .mc_returned_v_i    (mc_returned_v_i),
    .mc_returned_data_i (mc_returned_data_i),
    .mem_outstanding_i  (mem_outstanding),
    .core_cmd_ready_o   (core_cmd_ready_o),
    .core_resp_valid_o  (core_resp_valid_o),
    .core_resp_rd_o     (core_resp_rd_o),
    .core_resp_data_o   (core_resp_data_o),
    .acc_busy_o         (acc_busy_o),
    .read               (i_read_if.merge)
  );

endmodule

//--- verification/rocc_bridge_clk_gen.sv
`timescale 1ns/1ps

// 8 ns clock, reset held high for the first 10 cycles
module rocc_bridge_clk_gen (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  // release on a falling edge, away from the sampling edge
  initial begin
    reset_o = 1'b1;
    repeat (10) @(posedge clk_o);
    @(negedge clk_o);
    reset_o = 1'b0;
  end

endmodule

//--- verification/rocc_bridge_assertions.sv
`timescale 1ns/1ps

module rocc_bridge_assertions (
  input logic                                        rocket_clk_i,
  input logic                                        rocket_reset_i,
  input logic                                        core_cmd_valid_i,
  input logic                                        core_cmd_ready_o,
  input rocc_bridge_pkg::rocc_funct7_e               core_cmd_funct7_i,
  input logic [rocc_bridge_pkg::rocc_reg_width-1:0]  core_cmd_rd_i,
  input logic [rocc_bridge_pkg::rocc_addr_width-1:0] core_cmd_rs1_i,
  input logic [rocc_bridge_pkg::mc_data_width-1:0]   core_cmd_rs2_i,
  input logic                                        core_resp_valid_o,
  input logic [rocc_bridge_pkg::rocc_reg_width-1:0]  core_resp_rd_o,
  input logic [rocc_bridge_pkg::mc_data_width-1:0]   core_resp_data_o,
  input logic                                        acc_busy_o,
  input logic                                        reset_manycore_o,
  input logic                                        mc_out_v_o,
  input rocc_bridge_pkg::mc_op_e                     mc_out_op_o,
  input logic [rocc_bridge_pkg::mc_addr_width-1:0]   mc_out_addr_o,
  input logic [rocc_bridge_pkg::mc_data_width-1:0]   mc_out_data_o,
  input logic [rocc_bridge_pkg::mc_x_width-1:0]      mc_out_x_o,
  input logic [rocc_bridge_pkg::mc_y_width-1:0]      mc_out_y_o,
  input logic                                        mc_returned_v_i,
  input logic [rocc_bridge_pkg::mc_data_width-1:0]   mc_returned_data_i,
  input logic                                        mc_in_v_i,
  input logic [rocc_bridge_pkg::mc_addr_width-1:0]   mc_in_addr_i,
  input logic [rocc_bridge_pkg::mc_data_width-1:0]   mc_in_data_i,
  input logic                                        mc_in_we_i,
  input logic                                        mc_in_yumi_o,
  input logic                                        mem_req_valid_o,
  input logic                                        mem_req_ready_i,
  input logic [rocc_bridge_pkg::rocc_addr_width-1:0] mem_req_addr_o,
  input rocc_bridge_pkg::rocc_mem_cmd_e              mem_req_cmd_o,
  input logic [rocc_bridge_pkg::mc_data_width-1:0]   mem_req_data_o,
  input logic                                        mem_resp_valid_i,
  input rocc_bridge_pkg::rocc_mem_cmd_e              mem_resp_cmd_i,
  input logic                                        mc_returning_v_o
);

  logic                                       cmd_accept;
  logic                                       read_accept;
  logic                                       read_pending_m;
  logic                                       mem_outstanding_m;
  logic [rocc_bridge_pkg::rocc_reg_width-1:0] read_rd_m;
  logic [rocc_bridge_pkg::seg_addr_width-1:0] seg_m;
  int                                         error_count = 0;

  task automatic record_failure(input string msg);
    error_count++;
    $error("%s", msg);
  endtask

  ////////////////////////////////////////////////////////////
  // reference state rebuilt from the port handshakes
  ////////////////////////////////////////////////////////////

  assign cmd_accept  = core_cmd_valid_i & core_cmd_ready_o;
  assign read_accept = cmd_accept & (core_cmd_funct7_i == rocc_bridge_pkg::funct7_read);

  always_ff @(posedge rocket_clk_i) begin
    if (rocket_reset_i) begin
      read_pending_m    <= 1'b0;
      mem_outstanding_m <= 1'b0;
    end else begin
      read_pending_m    <= mc_returned_v_i ? 1'b0 : (read_pending_m | read_accept);
      mem_outstanding_m <= mem_resp_valid_i ? 1'b0
                           : (mem_outstanding_m | (mem_req_valid_o & mem_req_ready_i));
    end
    if (read_accept) begin
      read_rd_m <= core_cmd_rd_i;
    end
    // segment is rs1 above the 16-bit manycore byte address
    if (cmd_accept && core_cmd_funct7_i == rocc_bridge_pkg::funct7_seg_addr) begin
      seg_m <= core_cmd_rs1_i[31:16];
    end
  end

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  assert property (@(posedge rocket_clk_i) disable iff (rocket_reset_i)
    cmd_accept && core_cmd_funct7_i == rocc_bridge_pkg::funct7_mc_reset
    |=> reset_manycore_o ##1 !reset_manycore_o)
    else record_failure("manycore reset pulse is not exactly one cycle long");

  // y, x and word address sit in the low 23 bits of rs1
  assert property (@(posedge rocket_clk_i) disable iff (rocket_reset_i)
    core_cmd_valid_i && core_cmd_funct7_i == rocc_bridge_pkg::funct7_write && !read_pending_m
    |-> mc_out_v_o && mc_out_op_o == rocc_bridge_pkg::op_remote_store
        && {mc_out_y_o, mc_out_x_o, mc_out_addr_o} == core_cmd_rs1_i[22:0]
        && mc_out_data_o == core_cmd_rs2_i)
    else record_failure($sformatf("Fail mc_out_addr_o 0x%h mc_out_data_o 0x%h expected 0x%h 0x%h",
      $sampled(mc_out_addr_o), $sampled(mc_out_data_o),
      $sampled(core_cmd_rs1_i[13:0]), $sampled(core_cmd_rs2_i)));

  assert property (@(posedge rocket_clk_i) disable iff (rocket_reset_i)
    read_accept |-> mc_out_v_o && mc_out_op_o == rocc_bridge_pkg::op_remote_load)
    else record_failure("accepted read did not leave as a load packet");

  assert property (@(posedge rocket_clk_i) disable iff (rocket_reset_i)
    read_pending_m |-> !core_cmd_ready_o)
    else record_failure("command ready was high while a read was in flight");

  assert property (@(posedge rocket_clk_i) disable iff (rocket_reset_i)
    mc_returned_v_i && read_pending_m
    |-> core_resp_valid_o && core_resp_rd_o == read_rd_m
        && core_resp_data_o == mc_returned_data_i)
    else record_failure($sformatf(
      "Fail core_resp_data_o 0x%h core_resp_rd_o 0x%h expected 0x%h 0x%h",
      $sampled(core_resp_data_o), $sampled(core_resp_rd_o),
      $sampled(mc_returned_data_i), $sampled(read_rd_m)));

  assert property (@(posedge rocket_clk_i) disable iff (rocket_reset_i)
    mem_req_valid_o
    |-> mem_req_addr_o == {seg_m, mc_in_addr_i, 2'b00}
        && mem_req_cmd_o == (mc_in_we_i ? rocc_bridge_pkg::mem_store : rocc_bridge_pkg::mem_load))
    else record_failure($sformatf("Fail mem_req_addr_o 0x%h expected 0x%h",
      $sampled(mem_req_addr_o), {$sampled(seg_m), $sampled(mc_in_addr_i), 2'b00}));

  // store data goes to rocket unchanged
  assert property (@(posedge rocket_clk_i) disable iff (rocket_reset_i)
    mem_req_valid_o |-> mem_req_data_o == mc_in_data_i)
    else record_failure($sformatf("Fail mem_req_data_o 0x%h expected 0x%h",
      $sampled(mem_req_data_o), $sampled(mc_in_data_i)));

  assert property (@(posedge rocket_clk_i) disable iff (rocket_reset_i)
    mem_outstanding_m |-> !mem_req_valid_o && !mc_in_yumi_o)
    else record_failure("a second memory request was offered while one was outstanding");

  // stores complete without returning anything to the manycore
  assert property (@(posedge rocket_clk_i) disable iff (rocket_reset_i)
    mc_returning_v_o == (mem_resp_valid_i && mem_resp_cmd_i == rocc_bridge_pkg::mem_load))
    else record_failure("returned load valid does not follow the load responses");

  assert property (@(posedge rocket_clk_i) disable iff (rocket_reset_i)
    acc_busy_o == (read_pending_m || mem_outstanding_m))
    else record_failure($sformatf("Fail acc_busy_o 0x%h expected 0x%h",
      $sampled(acc_busy_o), $sampled(read_pending_m || mem_outstanding_m)));

  assert property (@(posedge rocket_clk_i)
    rocket_reset_i && $past(rocket_reset_i)
    |-> !reset_manycore_o && !mc_out_v_o && !mem_req_valid_o && !acc_busy_o
        && !core_resp_valid_o)
    else record_failure("an output was active during reset");

endmodule

//--- verification/rocc_bridge_tb.sv
`timescale 1ns/1ps

module rocc_bridge_tb;

  logic rocket_clk_i, rocket_reset_i;
  logic core_cmd_valid_i, core_cmd_ready_o, core_resp_valid_o, acc_busy_o;
  rocc_bridge_pkg::rocc_funct7_e core_cmd_funct7_i;
  logic [rocc_bridge_pkg::rocc_reg_width-1:0] core_cmd_rd_i, core_resp_rd_o;
  logic [rocc_bridge_pkg::rocc_addr_width-1:0] core_cmd_rs1_i, mem_req_addr_o;
  logic [rocc_bridge_pkg::mc_data_width-1:0] core_cmd_rs2_i, core_resp_data_o, mc_out_data_o;
  logic [rocc_bridge_pkg::mc_data_width-1:0] mc_returned_data_i, mc_in_data_i, mem_req_data_o;
  logic [rocc_bridge_pkg::mc_data_width-1:0] mem_resp_data_i, mc_returning_data_o;
  logic mc_out_v_o, mc_out_ready_i, mc_returned_v_i, reset_manycore_o;
  rocc_bridge_pkg::mc_op_e mc_out_op_o;
  logic [rocc_bridge_pkg::mc_addr_width-1:0] mc_out_addr_o, mc_in_addr_i;
  logic [rocc_bridge_pkg::mc_x_width-1:0] mc_out_x_o;
  logic [rocc_bridge_pkg::mc_y_width-1:0] mc_out_y_o;
  logic mc_in_v_i, mc_in_we_i, mc_in_yumi_o, mc_returning_v_o;
  logic mem_req_valid_o, mem_req_ready_i, mem_resp_valid_i;
  rocc_bridge_pkg::rocc_mem_cmd_e mem_req_cmd_o, mem_resp_cmd_i, mem_cmd_m;

  integer seed = 32'hb0e3fc62;
  // about ten times the length of all tests
  int cycle_limit = 4000;
  int cycle_count, test_id, hits, errors_before, read_wait, mem_wait;
  int tests_passed, tests_failed, value_errors;

  rocc_bridge_clk_gen i_clk_gen (.clk_o(rocket_clk_i), .reset_o(rocket_reset_i));
  rocc_bridge_top i_rocc_bridge_top (.*);
  bind rocc_bridge_top rocc_bridge_assertions i_rocc_bridge_assertions (.*);

  function automatic int error_total();
    return i_rocc_bridge_top.i_rocc_bridge_assertions.error_count + value_errors;
  endfunction

  ////////////////////////////////////////////////////////////
  // manycore and rocket memory models
  ////////////////////////////////////////////////////////////

  // triggers per test, response scheduling and the cycle limit
  always @(posedge rocket_clk_i) begin
    cycle_count++;
    if (!rocket_reset_i) begin
      case (test_id)
        1: hits += (core_cmd_valid_i && core_cmd_ready_o);
        2: hits += (core_cmd_valid_i && mc_out_v_o);
        3: hits += core_resp_valid_o;
        4: hits += mem_req_valid_o;
        5: hits += mc_returning_v_o;
        6: hits += acc_busy_o;
        default: ;
      endcase
    end
    if (mc_out_v_o && mc_out_ready_i && mc_out_op_o == rocc_bridge_pkg::op_remote_load) begin
      read_wait = 1 + {$random(seed)} % 4;
    end
    if (mem_req_valid_o && mem_req_ready_i) begin
      mem_wait  = 1 + {$random(seed)} % 4;
      mem_cmd_m = mem_req_cmd_o;
    end
    if (mc_returning_v_o && mc_returning_data_o !== mem_resp_data_i) begin
      $display("Fail mc_returning_data_o 0x%h expected 0x%h", mc_returning_data_o,
               mem_resp_data_i);
      value_errors++;
    end
    if (cycle_count >= cycle_limit) begin
      $display("timeout after %0d cycles, a handshake never completed", cycle_count);
      $display("Test failed");
      $finish;
    end
  end

  always @(negedge rocket_clk_i) begin
    mc_out_ready_i   <= ($random(seed) & 3) != 0;
    mem_req_ready_i  <= ($random(seed) & 3) != 0;
    mc_returned_v_i  <= 1'b0;
    mem_resp_valid_i <= 1'b0;
    if (read_wait > 0) begin
      read_wait--;
      mc_returned_v_i    <= (read_wait == 0);
      mc_returned_data_i <= $random(seed);
    end
    if (mem_wait > 0) begin
      mem_wait--;
      mem_resp_valid_i <= (mem_wait == 0);
      mem_resp_cmd_i   <= mem_cmd_m;
      mem_resp_data_i  <= $random(seed);
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  // called on a falling edge, returns on a falling edge
  task automatic send_command(input rocc_bridge_pkg::rocc_funct7_e funct7);
    core_cmd_valid_i  = 1'b1;
    core_cmd_funct7_i = funct7;
    core_cmd_rd_i     = $random(seed);
    core_cmd_rs1_i    = $random(seed);
    core_cmd_rs2_i    = $random(seed);
    @(posedge rocket_clk_i);
    while (!core_cmd_ready_o) begin
      @(posedge rocket_clk_i);
    end
    @(negedge rocket_clk_i);
    core_cmd_valid_i = 1'b0;
  endtask

  task automatic send_access(input logic we);
    mc_in_v_i    = 1'b1;
    mc_in_we_i   = we;
    mc_in_addr_i = $random(seed);
    mc_in_data_i = $random(seed);
    @(posedge rocket_clk_i);
    while (!mc_in_yumi_o) begin
      @(posedge rocket_clk_i);
    end
    @(negedge rocket_clk_i);
    mc_in_v_i = 1'b0;
  endtask

  task automatic start_test(input int id);
    test_id       = id;
    hits          = 0;
    errors_before = error_total();
  endtask

  // let every response come back before the tally
  task automatic end_test(input string name);
    while (acc_busy_o || read_wait > 0 || mem_wait > 0) begin
      @(posedge rocket_clk_i);
    end
    repeat (2) @(posedge rocket_clk_i);
    if (hits == 0) begin
      $display("%s: failed, its check was never reached", name);
      tests_failed++;
    end else if (error_total() != errors_before) begin
      $display("%s: failed, %0d checks went wrong", name, error_total() - errors_before);
      tests_failed++;
    end else begin
      $display("%s: passed, %0d triggers reached", name, hits);
      tests_passed++;
    end
    @(negedge rocket_clk_i);
  endtask

  initial begin
    {core_cmd_valid_i, mc_in_v_i, mc_in_we_i, mc_out_ready_i, mem_req_ready_i} = '0;
    {mc_returned_v_i, mem_resp_valid_i} = '0;
    {core_cmd_rd_i, core_cmd_rs1_i, core_cmd_rs2_i, mc_returned_data_i} = '0;
    {mc_in_addr_i, mc_in_data_i, mem_resp_data_i} = '0;
    core_cmd_funct7_i = rocc_bridge_pkg::funct7_write;
    mem_resp_cmd_i    = rocc_bridge_pkg::mem_load;
    @(negedge rocket_clk_i);
    while (rocket_reset_i) begin
      @(negedge rocket_clk_i);
    end
    start_test(1);
    send_command(rocc_bridge_pkg::funct7_mc_reset);
    end_test("manycore reset pulse");
    start_test(2);
    repeat (8) send_command(rocc_bridge_pkg::funct7_write);
    end_test("write packet");
    start_test(3);
    repeat (8) send_command(rocc_bridge_pkg::funct7_read);
    end_test("read response");
    start_test(4);
    send_command(rocc_bridge_pkg::funct7_seg_addr);
    for (int i = 0; i < 8; i++) begin
      send_access(i[0]);
    end
    end_test("segment address");
    start_test(5);
    for (int i = 0; i < 8; i++) begin
      send_access(i[1]);
    end
    end_test("single outstanding request");
    // read and memory access overlap
    start_test(6);
    fork
      send_command(rocc_bridge_pkg::funct7_read);
      send_access(1'b0);
    join
    end_test("busy flag");
    $display("tests passed %0d, tests failed %0d, failed checks %0d",
             tests_passed, tests_failed, error_total());
    if (tests_failed == 0 && error_total() == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- sim.f
source/rocc_bridge_pkg.sv
source/mc_read_if.sv
source/rocc_cmd_decoder.sv
source/mc_mem_port.sv
source/rocc_resp_merge.sv
source/rocc_bridge_top.sv
verification/rocc_bridge_clk_gen.sv
verification/rocc_bridge_assertions.sv
verification/rocc_bridge_tb.sv
